// File: Makefile
TOP = tb_uart_bridge

.PHONY: all lint clean

# Build, run, and pass only when the testbench reports success
all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge;

  localparam int CLKS_PER_BIT = 8;
  localparam int GAP_BITS     = 2;
  localparam int FIFO_DEPTH   = 4;
  // Two writes, one read, one bad read, then five queued commands of up to two frames
  localparam int TEST_FRAMES  = 18;
  localparam int WATCHDOG_CYC = TEST_FRAMES * uart_pkg::FRAME_BITS * CLKS_PER_BIT * 2;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        tx;
  logic        cmd_rdy;
  logic        read_rdy;
  logic [7:0]  read_data;
  logic        read_err;

  logic [7:0]  dev_mem [128];
  logic [7:0]  exp_mem [128];
  logic [7:0]  frames_q [$];
  logic        corrupt_parity;
  logic        reset_done;

  uart_bridge #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_BITS     (GAP_BITS),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) i_uart_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #2 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 11);
  endfunction

  // Mid-bit decode of one 8E1 frame on tx
  task automatic receive_frame(output logic [7:0] b);
    @(negedge clk);
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
    check_eq("tx start bit", 32'(tx), 0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      b[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_eq("tx parity bit", 32'(tx), 32'(^b));
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_eq("tx stop bit", 32'(tx), 1);
  endtask

  task automatic send_reply(input logic [7:0] b, input logic bad_parity);
    rx = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      rx = b[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx = (^b) ^ bad_parity;
    repeat (CLKS_PER_BIT) @(negedge clk);
    rx = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  // Remote register device on the far end of the line
  initial
  begin
    logic [7:0] hdr;
    logic [7:0] wdat;
    wait (reset_done === 1'b1);
    forever
    begin
      receive_frame(hdr);
      frames_q.push_back(hdr);
      if (hdr[7])
      begin
        receive_frame(wdat);
        dev_mem[hdr[6:0]] = wdat;
        frames_q.push_back(wdat);
      end
      else
      begin
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        send_reply(dev_mem[hdr[6:0]], corrupt_parity);
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout: the bridge did not finish its frames in time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  task automatic send_cmd(input logic is_write, input logic [6:0] addr, input logic [7:0] data);
    check_eq("cmd_rdy", 32'(cmd_rdy), 1);
    cmd_in  = {is_write, addr, data};
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic expect_frame(input string what, input logic [7:0] want);
    while (frames_q.size() == 0)
      @(negedge clk);
    check_eq(what, 32'(frames_q.pop_front()), 32'(want));
  endtask

  task automatic expect_read(input logic [7:0] data, input logic err);
    @(negedge clk);
    while (read_rdy !== 1'b1)
      @(negedge clk);
    check_eq("read_data", 32'(read_data), 32'(data));
    check_eq("read_err", 32'(read_err), 32'(err));
    @(negedge clk);
    check_eq("read_rdy", 32'(read_rdy), 0);
  endtask

  task automatic test_reset();
    repeat (4) @(negedge clk);
    check_eq("tx", 32'(tx), 1);
    check_eq("cmd_rdy", 32'(cmd_rdy), 1);
    check_eq("read_rdy", 32'(read_rdy), 0);
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("tx", 32'(tx), 1);
    check_eq("cmd_rdy", 32'(cmd_rdy), 1);
    check_eq("read_rdy", 32'(read_rdy), 0);
    reset_done = 1'b1;
  endtask

  task automatic test_write(input logic [6:0] addr, input logic [7:0] data);
    send_cmd(1'b1, addr, data);
    expect_frame("write header", {1'b1, addr});
    expect_frame("write data", data);
    check_eq("device register", 32'(dev_mem[addr]), 32'(data));
    exp_mem[addr] = data;
  endtask

  task automatic test_read(input logic [6:0] addr);
    send_cmd(1'b0, addr, 8'h00);
    expect_frame("read header", {1'b0, addr});
    expect_read(exp_mem[addr], 1'b0);
  endtask

  task automatic test_parity_err(input logic [6:0] addr);
    corrupt_parity = 1'b1;
    send_cmd(1'b0, addr, 8'h00);
    expect_frame("read header", {1'b0, addr});
    expect_read(exp_mem[addr], 1'b1);
    corrupt_parity = 1'b0;
  endtask

  task automatic test_queue();
    logic [15:0] cmds [5];
    logic [15:0] accepted [$];
    logic [15:0] c;
    for (int i = 0; i < 5; i++)
      cmds[i] = 16'($urandom());
    // Strobe on back-to-back cycles and keep only what cmd_rdy lets in
    for (int i = 0; i < 5; i++)
    begin
      cmd_in  = cmds[i];
      cmd_vld = 1'b1;
      if (cmd_rdy)
        accepted.push_back(cmds[i]);
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    check_eq("commands accepted", 32'(accepted.size()), FIFO_DEPTH + 1);
    check_eq("cmd_rdy when full", 32'(cmd_rdy), 0);
    while (accepted.size() > 0)
    begin
      c = accepted.pop_front();
      expect_frame("queued header", c[15:8]);
      if (c[15])
      begin
        expect_frame("queued data", c[7:0]);
        check_eq("device register", 32'(dev_mem[c[14:8]]), 32'(c[7:0]));
        exp_mem[c[14:8]] = c[7:0];
      end
      else
        expect_read(exp_mem[c[14:8]], 1'b0);
    end
  endtask

  initial
  begin
    logic [6:0] a1;
    logic [6:0] a2;
    void'($urandom(82));
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    rx             = 1'b1;
    corrupt_parity = 1'b0;
    reset_done     = 1'b0;
    for (int a = 0; a < 128; a++)
    begin
      dev_mem[a] = fill_byte(a);
      exp_mem[a] = fill_byte(a);
    end
    test_reset();
    a1 = 7'($urandom());
    a2 = a1 ^ 7'h40;
    test_write(a1, 8'($urandom()));
    test_write(a2, 8'($urandom()));
    test_read(a1);
    test_parity_err(a2);
    test_queue();
    repeat (2 * CLKS_PER_BIT) @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: files.f
src/uart_pkg.sv
src/cmd_pkg.sv
src/serial_if.sv
src/cmd_fifo.sv
src/uart_tx_serializer.sv
src/uart_rx_sampler.sv
src/uart_cmd_ctrl.sv
src/uart_bridge.sv
bench/tb_uart_bridge.sv

// File: src/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter type payload_t  = logic [15:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr_en,
  input  payload_t wr_data,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign full    = (count == CNT_FULL);
  assign empty   = (count == '0);
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);
  a_count_range: assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_FULL);

endmodule

// File: src/cmd_pkg.sv
package cmd_pkg;

  // Host command word layout
  localparam int ADDR_BITS  = 7;
  localparam int WDATA_BITS = 8;
  localparam int CMD_BITS   = 1 + ADDR_BITS + WDATA_BITS;

  typedef struct packed {
    logic                  is_write;
    logic [ADDR_BITS-1:0]  addr;
    logic [WDATA_BITS-1:0] data;
  } cmd_t;

  // Command sequencer states
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_LOAD    = 3'd1,
    ST_HDR     = 3'd2,
    ST_GAP     = 3'd3,
    ST_DATA    = 3'd4,
    ST_WAIT    = 3'd5,
    ST_DELIVER = 3'd6
  } ctrl_state_t;

endpackage

// File: src/serial_if.sv
`timescale 1ns/1ps

interface serial_if (
  input logic clk
);

  // Transmit side, one frame at a time
  logic                           tx_start;
  logic [uart_pkg::DATA_BITS-1:0] tx_byte;
  logic                           tx_done;

  // Receive side
  logic                           rx_valid;
  logic [uart_pkg::DATA_BITS-1:0] rx_byte;
  logic                           rx_perr;

  modport ctrl (input clk, output tx_start, output tx_byte, input tx_done,
                input rx_valid, input rx_byte, input rx_perr);

  modport ser (input clk, input tx_start, input tx_byte, output tx_done);

  modport smp (input clk, output rx_valid, output rx_byte, output rx_perr);

endinterface

// File: src/uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_BITS     = 16,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [cmd_pkg::CMD_BITS-1:0]   cmd_in,
  input  logic                           cmd_vld,
  input  logic                           rx,
  output logic                           tx,
  output logic                           cmd_rdy,
  output logic                           read_rdy,
  output logic [uart_pkg::DATA_BITS-1:0] read_data,
  output logic                           read_err
);

  cmd_pkg::cmd_t fifo_head;
  logic          fifo_empty;
  logic          fifo_full;
  logic          fifo_pop;
  logic          fifo_wr;

  // Strobes without space are dropped here
  assign cmd_rdy = !fifo_full;
  assign fifo_wr = cmd_vld && cmd_rdy;

  serial_if i_serial (.clk(clk));

  cmd_fifo #(
    .payload_t  (cmd_pkg::cmd_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (fifo_wr),
    .wr_data (cmd_pkg::cmd_t'(cmd_in)),
    .rd_en   (fifo_pop),
    .rd_data (fifo_head),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  uart_cmd_ctrl #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_BITS     (GAP_BITS)
  ) i_uart_cmd_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_head  (fifo_head),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .read_rdy   (read_rdy),
    .read_data  (read_data),
    .read_err   (read_err),
    .bus        (i_serial.ctrl)
  );

  uart_tx_serializer #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx_serializer (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (i_serial.ser),
    .tx    (tx)
  );

  uart_rx_sampler #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx_sampler (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .bus   (i_serial.smp)
  );

endmodule

// File: src/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_BITS     = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  cmd_pkg::cmd_t                  fifo_head,
  input  logic                           fifo_empty,
  output logic                           fifo_pop,
  output logic                           read_rdy,
  output logic [uart_pkg::DATA_BITS-1:0] read_data,
  output logic                           read_err,
  serial_if.ctrl                         bus
);

  localparam int GAP_CYC = GAP_BITS * CLKS_PER_BIT;
  localparam int GAP_W   = $clog2(GAP_CYC + 1);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYC - 1);

  cmd_pkg::ctrl_state_t state;
  cmd_pkg::ctrl_state_t state_nxt;
  cmd_pkg::cmd_t        cmd_q;
  logic [GAP_W-1:0]     gap_cnt;
  logic                 gap_done;
  logic                 in_hdr;

  assign gap_done = (gap_cnt == GAP_LAST);
  assign in_hdr   = (state == cmd_pkg::ST_LOAD) || (state == cmd_pkg::ST_HDR);
  assign fifo_pop = (state == cmd_pkg::ST_IDLE) && !fifo_empty;
  assign read_rdy = (state == cmd_pkg::ST_DELIVER);

  // Header frame from LOAD, data frame at the end of the gap
  assign bus.tx_start = (state == cmd_pkg::ST_LOAD) ||
                        (state == cmd_pkg::ST_GAP && gap_done);
  assign bus.tx_byte  = in_hdr ? {cmd_q.is_write, cmd_q.addr} : cmd_q.data;

  always_ff @(posedge clk)
  begin
    if (fifo_pop)
      cmd_q <= fifo_head;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      cmd_pkg::ST_IDLE:
      begin
        if (!fifo_empty)
          state_nxt = cmd_pkg::ST_LOAD;
      end
      cmd_pkg::ST_LOAD:
        state_nxt = cmd_pkg::ST_HDR;
      cmd_pkg::ST_HDR:
      begin
        if (bus.tx_done)
          state_nxt = cmd_q.is_write ? cmd_pkg::ST_GAP : cmd_pkg::ST_WAIT;
      end
      cmd_pkg::ST_GAP:
      begin
        if (gap_done)
          state_nxt = cmd_pkg::ST_DATA;
      end
      cmd_pkg::ST_DATA:
      begin
        if (bus.tx_done)
          state_nxt = cmd_pkg::ST_IDLE;
      end
      cmd_pkg::ST_WAIT:
      begin
        // No timeout, a lost reply stalls here
        if (bus.rx_valid)
          state_nxt = cmd_pkg::ST_DELIVER;
      end
      cmd_pkg::ST_DELIVER:
        state_nxt = cmd_pkg::ST_IDLE;
      default:
        state_nxt = cmd_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= cmd_pkg::ST_IDLE;
      gap_cnt   <= '0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == cmd_pkg::ST_GAP)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
      if (state == cmd_pkg::ST_WAIT && bus.rx_valid)
      begin
        read_data <= bus.rx_byte;
        read_err  <= bus.rx_perr;
      end
    end
  end

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy);

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

  // Serial line format, fixed at 8E1
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 1 + DATA_BITS + 1 + 1;

  // Position within one frame
  typedef enum logic [2:0] {
    PH_IDLE   = 3'd0,
    PH_START  = 3'd1,
    PH_DATA   = 3'd2,
    PH_PARITY = 3'd3,
    PH_STOP   = 3'd4
  } bit_phase_t;

endpackage

// File: src/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  serial_if.smp bus
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(uart_pkg::DATA_BITS - 1);

  uart_pkg::bit_phase_t           phase;
  logic [CNT_W-1:0]               clk_cnt;
  logic [IDX_W-1:0]               bit_idx;
  logic [uart_pkg::DATA_BITS-1:0] shreg;
  logic                           par_q;
  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           fall;
  logic                           bit_end;
  logic                           mid_start;

  assign fall      = rx_prev && !rx_sync;
  assign bit_end   = (clk_cnt == BIT_LAST);
  assign mid_start = (clk_cnt == HALF_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Sampled bits and the reported result
  always_ff @(posedge clk)
  begin
    if (phase == uart_pkg::PH_DATA && bit_end)
      shreg <= {rx_sync, shreg[uart_pkg::DATA_BITS-1:1]};
    if (phase == uart_pkg::PH_PARITY && bit_end)
      par_q <= rx_sync;
    if (phase == uart_pkg::PH_STOP && bit_end)
    begin
      bus.rx_byte <= shreg;
      bus.rx_perr <= (par_q != ^shreg) || !rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase        <= uart_pkg::PH_IDLE;
      clk_cnt      <= '0;
      bit_idx      <= '0;
      bus.rx_valid <= 1'b0;
    end
    else
    begin
      bus.rx_valid <= 1'b0;
      case (phase)
        uart_pkg::PH_IDLE:
        begin
          clk_cnt <= '0;
          if (fall)
            phase <= uart_pkg::PH_START;
        end
        uart_pkg::PH_START:
        begin
          clk_cnt <= clk_cnt + 1'b1;
          if (mid_start)
          begin
            // High at mid start bit means noise
            phase   <= rx_sync ? uart_pkg::PH_IDLE : uart_pkg::PH_DATA;
            clk_cnt <= '0;
            bit_idx <= '0;
          end
        end
        default:
        begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end)
          begin
            case (phase)
              uart_pkg::PH_DATA:
              begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == IDX_LAST)
                  phase <= uart_pkg::PH_PARITY;
              end
              uart_pkg::PH_PARITY:
                phase <= uart_pkg::PH_STOP;
              default:
              begin
                phase        <= uart_pkg::PH_IDLE;
                bus.rx_valid <= 1'b1;
              end
            endcase
          end
        end
      endcase
    end
  end

endmodule

// File: src/uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  serial_if.ser bus,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_pkg::DATA_BITS - 1);

  uart_pkg::bit_phase_t           phase;
  logic [CNT_W-1:0]               clk_cnt;
  logic [IDX_W-1:0]               bit_idx;
  logic [uart_pkg::DATA_BITS-1:0] data_q;
  logic                           parity_q;
  logic                           bit_end;
  logic                           launch;
  logic                           shift;

  assign bit_end = (clk_cnt == BIT_LAST);
  assign launch  = bus.tx_start && (phase == uart_pkg::PH_IDLE);
  assign shift   = bit_end && (phase == uart_pkg::PH_START || phase == uart_pkg::PH_DATA);

  // Data byte shifts right, LSB always on bit 0
  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      data_q   <= bus.tx_byte;
      parity_q <= ^bus.tx_byte;
    end
    else if (shift)
      data_q <= {1'b0, data_q[uart_pkg::DATA_BITS-1:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase       <= uart_pkg::PH_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      tx          <= 1'b1;
      bus.tx_done <= 1'b0;
    end
    else
    begin
      bus.tx_done <= 1'b0;
      if (phase != uart_pkg::PH_IDLE)
        clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (phase)
        uart_pkg::PH_IDLE:
        begin
          if (launch)
          begin
            phase <= uart_pkg::PH_START;
            tx    <= 1'b0;
          end
        end
        uart_pkg::PH_START:
        begin
          if (bit_end)
          begin
            phase   <= uart_pkg::PH_DATA;
            bit_idx <= '0;
            tx      <= data_q[0];
          end
        end
        uart_pkg::PH_DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == IDX_LAST)
            begin
              phase <= uart_pkg::PH_PARITY;
              tx    <= parity_q;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= data_q[0];
            end
          end
        end
        uart_pkg::PH_PARITY:
        begin
          if (bit_end)
          begin
            phase <= uart_pkg::PH_STOP;
            tx    <= 1'b1;
          end
        end
        uart_pkg::PH_STOP:
        begin
          if (bit_end)
          begin
            phase       <= uart_pkg::PH_IDLE;
            bus.tx_done <= 1'b1;
          end
        end
        default:
          phase <= uart_pkg::PH_IDLE;
      endcase
    end
  end

  // Controller must wait for tx_done before the next frame
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus.tx_start |-> phase == uart_pkg::PH_IDLE);

endmodule
